// ==== design/fetch_config.svh ====
// ------------------------------------------------
// widths and counts shared by the fetch frontend
// a fetch word holds exactly FETCH_SLOTS 32-bit instructions
// ------------------------------------------------
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// virtual address width in bits
`define FETCH_VLEN 32

// instruction slots per fetch word
`define FETCH_SLOTS 2

// fetch word width in bits
`define FETCH_WIDTH 64

`endif

// ==== design/fetch_pkg.sv ====
// ------------------------------------------------
// types for the fetch frontend
// RV32 encodings only and no compressed instructions
// ------------------------------------------------
`include "fetch_config.svh"

package fetch_pkg;

    // byte offset bits inside one fetch word
    localparam int unsigned OFFSET_W = $clog2(`FETCH_WIDTH / 8);

    // major opcodes that change control flow
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    typedef logic [`FETCH_VLEN-1:0] addr_t;

    // ------------------------------------------------
    // instruction word views
    // ------------------------------------------------
    typedef struct packed {
        logic [24:0] rest;
        logic [6:0]  opcode;
    } raw_view_t;

    // imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } btype_view_t;

    // imm[20|10:1|11|19:12] rd opcode
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_view_t;

    typedef union packed {
        raw_view_t   raw;
        btype_view_t btype;
        jtype_view_t jtype;
    } instr_word_u;

    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP
    } cf_kind_e;

    // ------------------------------------------------
    // port bundles
    // ------------------------------------------------
    typedef struct packed {
        logic        valid;
        addr_t       addr;
        instr_word_u instr;
    } slot_t;

    typedef struct packed {
        cf_kind_e           kind;
        logic signed [31:0] imm;
    } scan_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                    valid;
        addr_t                   addr;
        logic [`FETCH_WIDTH-1:0] data;
    } fetch_rsp_t;

    // trap and resolve share this shape
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        addr_t       addr;
        instr_word_u instr;
        logic        taken;
        addr_t       target;
    } issue_entry_t;

    typedef struct packed {
        logic [`FETCH_SLOTS-1:0]         valid;
        issue_entry_t [`FETCH_SLOTS-1:0] entry;
    } issue_t;

endpackage

// ==== design/fetch_align.sv ====
// ------------------------------------------------
// holds one accepted fetch word for a single cycle
// assumes a 4-byte aligned PC and one outstanding fetch
// ------------------------------------------------
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_align (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  fetch_pkg::fetch_rsp_t               fetch_rsp_i,
    input  fetch_pkg::addr_t                    pc_i,
    input  logic                                flush_i,
    output fetch_pkg::slot_t [`FETCH_SLOTS-1:0] slots_o
);
    import fetch_pkg::*;

    logic                    accept;
    addr_t                   rsp_base;
    logic [`FETCH_SLOTS-1:0] slot_hit;
    logic [`FETCH_SLOTS-1:0] valid_q;
    addr_t                   base_q;
    logic [`FETCH_WIDTH-1:0] data_q;

    // ------------------------------------------------
    // response acceptance
    // ------------------------------------------------
    // only the answer to the current PC counts
    // anything else belongs to a fetch that a redirect abandoned
    assign accept   = fetch_rsp_i.valid && (fetch_rsp_i.addr == pc_i);
    assign rsp_base = {fetch_rsp_i.addr[`FETCH_VLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // slots below the PC are skipped
    // e.g. slot 0 after a jump into the upper half of the word
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            slot_hit[i] = (rsp_base + addr_t'(4 * i)) >= pc_i;
        end
    end

    // valid bits live for one cycle
    // a redirect in the response cycle kills the word
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= (accept && !flush_i) ? slot_hit : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            base_q <= rsp_base;
            data_q <= fetch_rsp_i.data;
        end
    end

    // ------------------------------------------------
    // slot split
    // ------------------------------------------------
    // lowest address sits in the low word
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            slots_o[i].valid = valid_q[i];
            slots_o[i].addr  = base_q + addr_t'(4 * i);
            slots_o[i].instr = data_q[32*i +: 32];
        end
    end

    // steer waits for the slots before it asks again
    // so two accepted words never come back to back
    a_single_accept: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        accept |-> (valid_q == '0)
    );

endmodule

// ==== design/cf_scan.sv ====
// ------------------------------------------------
// static control flow scan of one RV32 slot
// JALR and returns are reported as plain instructions
// ------------------------------------------------
`timescale 1ns/1ns

module cf_scan (
    input  fetch_pkg::slot_t slot_i,
    output fetch_pkg::scan_t scan_o
);
    import fetch_pkg::*;

    instr_word_u        word;
    logic signed [31:0] b_imm;
    logic signed [31:0] j_imm;

    assign word = slot_i.instr;

    // ------------------------------------------------
    // immediates
    // ------------------------------------------------
    // both views read the same word
    // only the opcode decides which one is kept
    // B-type offset is 13 bits with bit 0 forced low
    assign b_imm = {{19{word.btype.imm12}},
                    word.btype.imm12,
                    word.btype.imm11,
                    word.btype.imm10_5,
                    word.btype.imm4_1,
                    1'b0};

    // J-type offset is 21 bits with bit 0 forced low
    assign j_imm = {{11{word.jtype.imm20}},
                    word.jtype.imm20,
                    word.jtype.imm19_12,
                    word.jtype.imm11,
                    word.jtype.imm10_1,
                    1'b0};

    // ------------------------------------------------
    // classification
    // ------------------------------------------------
    always_comb begin
        scan_o.kind = CF_NONE;
        scan_o.imm  = '0;
        // empty slots never predict
        if (slot_i.valid) begin
            case (word.raw.opcode)
                OPCODE_BRANCH: begin
                    scan_o.kind = CF_BRANCH;
                    scan_o.imm  = b_imm;
                end
                OPCODE_JAL: begin
                    scan_o.kind = CF_JUMP;
                    scan_o.imm  = j_imm;
                end
                default: begin
                    scan_o.kind = CF_NONE;
                end
            endcase
        end
    end

endmodule

// ==== design/fetch_steer.sv ====
// ------------------------------------------------
// static prediction, issue bundle and PC generation
// no back-pressure so every bundle must be taken by the back-end
// ------------------------------------------------
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_steer (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  fetch_pkg::addr_t                    boot_addr_i,
    input  fetch_pkg::redirect_t                trap_i,
    input  fetch_pkg::redirect_t                resolve_i,
    input  fetch_pkg::slot_t [`FETCH_SLOTS-1:0] slots_i,
    input  fetch_pkg::scan_t [`FETCH_SLOTS-1:0] scan_i,
    output fetch_pkg::addr_t                    pc_o,
    output logic                                flush_o,
    output fetch_pkg::fetch_req_t               fetch_req_o,
    output fetch_pkg::issue_t                   issue_o
);
    import fetch_pkg::*;

    addr_t                      pc_q;
    addr_t                      pc_d;
    addr_t                      seq_pc;
    logic                       rst_load_q;
    logic                       req_q;
    logic                       req_d;
    logic                       pending_q;
    logic                       pending_d;
    logic                       redirect;
    logic                       arrive;
    logic [`FETCH_SLOTS-1:0]    slot_valid;
    logic [`FETCH_SLOTS-1:0]    slot_taken;
    logic [`FETCH_SLOTS-1:0]    taken_vec;
    addr_t [`FETCH_SLOTS-1:0]   slot_target;
    logic                       pred_valid;
    addr_t                      pred_target;

    assign redirect = trap_i.valid || resolve_i.valid;
    assign flush_o  = redirect;
    assign pc_o     = pc_q;

    // ------------------------------------------------
    // per slot prediction
    // ------------------------------------------------
    // jal always taken, backward branch taken
    // invalid slots already scan as CF_NONE
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            slot_valid[i]  = slots_i[i].valid;
            slot_target[i] = slots_i[i].addr + addr_t'(scan_i[i].imm);
            slot_taken[i]  = (scan_i[i].kind == CF_JUMP) ||
                             ((scan_i[i].kind == CF_BRANCH) && scan_i[i].imm[31]);
        end
    end

    // ------------------------------------------------
    // issue bundle
    // ------------------------------------------------
    always_comb begin
        logic seen;
        seen        = 1'b0;
        taken_vec   = '0;
        pred_valid  = 1'b0;
        pred_target = '0;
        issue_o     = '0;
        // lowest taken slot wins and everything after it is dropped
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            issue_o.valid[i]       = slot_valid[i] && !seen && !redirect;
            issue_o.entry[i].addr  = slots_i[i].addr;
            issue_o.entry[i].instr = slots_i[i].instr;
            if (!seen && slot_taken[i]) begin
                taken_vec[i] = 1'b1;
                seen         = 1'b1;
                pred_valid   = 1'b1;
                pred_target  = slot_target[i];
            end
            issue_o.entry[i].taken = taken_vec[i];
            // untaken entries point at their fall-through
            issue_o.entry[i].target = taken_vec[i] ? slot_target[i]
                                                   : slots_i[i].addr + addr_t'(4);
        end
    end

    // ------------------------------------------------
    // next PC and request control
    // ------------------------------------------------
    assign seq_pc = {pc_q[`FETCH_VLEN-1:OFFSET_W], {OFFSET_W{1'b0}}}
                  + addr_t'(`FETCH_WIDTH / 8);

    // slots only count while a fetch is in flight
    assign arrive = pending_q && (|slot_valid);

    // trap over resolve over prediction over sequential
    always_comb begin
        pc_d = pc_q;
        if (rst_load_q) begin
            pc_d = boot_addr_i;
        end else if (trap_i.valid) begin
            pc_d = trap_i.target;
        end else if (resolve_i.valid) begin
            pc_d = resolve_i.target;
        end else if (arrive) begin
            pc_d = pred_valid ? pred_target : seq_pc;
        end
    end

    // request goes out one cycle after the PC settles
    assign req_d     = rst_load_q || redirect || arrive;
    assign pending_d = req_q || (pending_q && !arrive);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q <= 1'b1;
            pc_q       <= '0;
            req_q      <= 1'b0;
            pending_q  <= 1'b0;
        end else begin
            rst_load_q <= 1'b0;
            pc_q       <= pc_d;
            req_q      <= req_d;
            pending_q  <= pending_d;
        end
    end

    assign fetch_req_o.valid = req_q;
    assign fetch_req_o.addr  = pc_q;

    // a redirect also kills the word that answers in its own cycle
    // which only holds if align drops it on flush
    a_no_issue_on_redirect: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (redirect || $past(redirect)) |-> (issue_o.valid == '0)
    );

    // only one slot predicts and it always holds an instruction
    // which relies on scan reporting empty slots as CF_NONE
    a_one_taken: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0(taken_vec) && ((taken_vec & ~slot_valid) == '0)
    );

endmodule

// ==== design/fetch_frontend.sv ====
// ------------------------------------------------
// fetch frontend top with one fetch in flight
// memory must answer every request exactly once
// ------------------------------------------------
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_frontend (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  fetch_pkg::addr_t      boot_addr_i,
    // instruction memory
    output fetch_pkg::fetch_req_t fetch_req_o,
    input  fetch_pkg::fetch_rsp_t fetch_rsp_i,
    // redirects from the back-end
    input  fetch_pkg::redirect_t  trap_i,
    input  fetch_pkg::redirect_t  resolve_i,
    // to the back-end
    output fetch_pkg::issue_t     issue_o
);
    import fetch_pkg::*;

    addr_t                    pc;
    logic                     flush;
    slot_t [`FETCH_SLOTS-1:0] slots;
    scan_t [`FETCH_SLOTS-1:0] scans;

    // ------------------------------------------------
    // response register and slot split
    // ------------------------------------------------
    fetch_align i_fetch_align (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .fetch_rsp_i ( fetch_rsp_i ),
        .pc_i        ( pc          ),
        .flush_i     ( flush       ),
        .slots_o     ( slots       )
    );

    // one scanner per slot
    for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : gen_scan
        cf_scan i_cf_scan (
            .slot_i ( slots[i] ),
            .scan_o ( scans[i] )
        );
    end

    // ------------------------------------------------
    // prediction, issue and PC
    // ------------------------------------------------
    fetch_steer i_fetch_steer (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .boot_addr_i ( boot_addr_i ),
        .trap_i      ( trap_i      ),
        .resolve_i   ( resolve_i   ),
        .slots_i     ( slots       ),
        .scan_i      ( scans       ),
        .pc_o        ( pc          ),
        .flush_o     ( flush       ),
        .fetch_req_o ( fetch_req_o ),
        .issue_o     ( issue_o     )
    );

endmodule

// ==== verif/tb_fetch_frontend.sv ====
// --------------------------------------------------
// random and directed fetch traffic against a cycle model of the frontend
// memory answers in request order and redirect targets avoid in-flight addresses
// --------------------------------------------------
`timescale 1ns/1ns
`include "fetch_config.svh"

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam int          MEM_WORDS = 256;
    localparam logic [31:0] NOP       = 32'h0000_0013;

    logic       clk_i;
    logic       rst_ni;
    addr_t      boot_addr;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    redirect_t  trap;
    redirect_t  resolve;
    issue_t     issue;

    logic [31:0] mem [MEM_WORDS];
    logic [15:0] lfsr_q;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          fetch_count;
    logic        timed_out;

    // outstanding requests seen by the memory with the oldest first
    addr_t q_addr[$];
    int    q_delay[$];

    // reference model state for the current cycle
    addr_t      m_pc;
    addr_t      m_base;
    logic       m_req;
    logic       m_pend;
    logic       m_boot;
    logic [1:0] m_sv;

    fetch_frontend i_fetch_frontend (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .boot_addr_i ( boot_addr ),
        .fetch_req_o ( fetch_req ),
        .fetch_rsp_i ( fetch_rsp ),
        .trap_i      ( trap      ),
        .resolve_i   ( resolve   ),
        .issue_o     ( issue     )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // random source and instruction encoders
    // --------------------------------------------------
    // taps x^16 + x^14 + x^13 + x^11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // beq x1, x2 with a 13-bit offset
    function automatic logic [31:0] enc_branch(input logic [31:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // jal x1 with a 21-bit offset
    function automatic logic [31:0] enc_jal(input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    // memory wraps on the word index
    function automatic logic [31:0] mem_word(input addr_t a);
        return mem[a[9:2]];
    endfunction

    // jal is always taken and a branch only with a negative offset
    function automatic void predict_slot(input logic [31:0] w, input addr_t a,
                                         output logic taken, output addr_t tgt);
        logic [31:0] off;
        taken = 1'b0;
        off   = 32'd4;
        if (w[6:0] == 7'b1101111) begin
            off   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            taken = 1'b1;
        end else if (w[6:0] == 7'b1100011 && w[31]) begin
            off   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            taken = 1'b1;
        end
        tgt = a + off;
    endfunction

    // about a quarter branches and a quarter jal with small nonzero offsets
    task automatic fill_random();
        logic [1:0]  kind;
        logic [31:0] mag;
        for (int i = 0; i < MEM_WORDS; i++) begin
            kind = 2'(rand_bits(2));
            mag  = (rand_bits(4) + 32'd1) * 32'd4;
            case (kind)
                2'd0:    mem[i] = enc_branch(rand_bits(1) != 0 ? -mag : mag);
                2'd1:    mem[i] = enc_jal(rand_bits(1) != 0 ? -mag : mag);
                default: mem[i] = NOP;
            endcase
        end
    endtask

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_req(input fetch_req_t act, input fetch_req_t exp);
        if (act.valid !== exp.valid || (exp.valid && act.addr !== exp.addr)) begin
            $display("MISMATCH %0t fetch_req_o act=%h exp=%h", $time, act, exp);
            errors++;
        end
    endtask

    // entries behind a cleared valid bit carry no meaning
    task automatic check_issue(input issue_t act, input issue_t exp);
        logic bad;
        bad = (act.valid !== exp.valid);
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            if (exp.valid[i] && act.entry[i] !== exp.entry[i]) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("MISMATCH %0t issue_o act=%h exp=%h", $time, act, exp);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // memory and back-end stimulus
    // --------------------------------------------------
    function automatic logic target_free(input addr_t t);
        if (t == m_pc) begin
            return 1'b0;
        end
        foreach (q_addr[i]) begin
            if (q_addr[i] == t) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drive_inputs(input int rate);
        addr_t      a;
        addr_t      t_trap;
        addr_t      t_res;
        logic [1:0] sel;
        fetch_rsp = '0;
        trap      = '0;
        resolve   = '0;
        // only the oldest request counts down
        if (q_addr.size() > 0) begin
            q_delay[0]--;
            if (q_delay[0] == 0) begin
                a               = {q_addr[0][31:3], 3'b000};
                fetch_rsp.valid = 1'b1;
                fetch_rsp.addr  = q_addr[0];
                fetch_rsp.data  = {mem_word(a + 32'd4), mem_word(a)};
                void'(q_addr.pop_front());
                void'(q_delay.pop_front());
            end
        end
        if (rate != 0 && int'(rand_bits(4)) < rate) begin
            sel    = 2'(rand_bits(2));
            t_trap = {22'd0, 8'(rand_bits(8)), 2'b00};
            t_res  = {22'd0, 8'(rand_bits(8)), 2'b00};
            if (target_free(t_trap) && target_free(t_res)) begin
                trap.valid     = (sel != 2'd1);
                trap.target    = t_trap;
                resolve.valid  = (sel != 2'd0);
                resolve.target = t_res;
            end
        end
    endtask

    task automatic capture_request();
        if (fetch_req.valid) begin
            q_addr.push_back(fetch_req.addr);
            q_delay.push_back(1 + int'(rand_bits(2)));
        end
    endtask

    // --------------------------------------------------
    // reference model checks one cycle and then advances
    // --------------------------------------------------
    task automatic step_model();
        fetch_req_t exp_req;
        issue_t     exp_issue;
        logic       redirect;
        logic       seen;
        logic       pred;
        logic       taken;
        logic       arrive;
        logic       accept;
        logic [1:0] hit;
        addr_t      a;
        addr_t      tgt;
        addr_t      pred_tgt;
        addr_t      rbase;
        addr_t      next_pc;
        exp_req.valid = m_req;
        exp_req.addr  = m_pc;
        check_req(fetch_req, exp_req);
        redirect  = trap.valid || resolve.valid;
        exp_issue = '0;
        seen      = 1'b0;
        pred      = 1'b0;
        pred_tgt  = '0;
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            a = m_base + addr_t'(4 * i);
            predict_slot(mem_word(a), a, taken, tgt);
            taken = taken && m_sv[i] && !seen;
            exp_issue.valid[i]        = m_sv[i] && !seen && !redirect;
            exp_issue.entry[i].addr   = a;
            exp_issue.entry[i].instr  = mem_word(a);
            exp_issue.entry[i].taken  = taken;
            exp_issue.entry[i].target = taken ? tgt : a + 32'd4;
            if (taken) begin
                pred     = 1'b1;
                pred_tgt = tgt;
                seen     = 1'b1;
            end
        end
        check_issue(issue, exp_issue);
        // state update at the coming rising edge
        arrive = m_pend && (m_sv != 2'b00);
        rbase  = {fetch_rsp.addr[31:3], 3'b000};
        accept = fetch_rsp.valid && (fetch_rsp.addr == m_pc);
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            hit[i] = (rbase + addr_t'(4 * i)) >= m_pc;
        end
        if (m_boot) begin
            next_pc = boot_addr;
        end else if (trap.valid) begin
            next_pc = trap.target;
        end else if (resolve.valid) begin
            next_pc = resolve.target;
        end else if (arrive) begin
            next_pc = pred ? pred_tgt : {m_pc[31:3], 3'b000} + 32'd8;
        end else begin
            next_pc = m_pc;
        end
        if (m_req) begin
            fetch_count++;
        end
        m_pend = m_req || (m_pend && !arrive);
        m_req  = m_boot || redirect || arrive;
        m_sv   = (accept && !redirect) ? hit : 2'b00;
        if (accept) begin
            m_base = rbase;
        end
        m_boot = 1'b0;
        m_pc   = next_pc;
    endtask

    // --------------------------------------------------
    // one test resets the DUT and runs until enough requests went out
    // --------------------------------------------------
    task automatic run_test(input string name, input addr_t boot, input int fetches,
                            input int rate);
        int limit;
        int cycles;
        int start_errors;
        if (timed_out) begin
            return;
        end
        start_errors = errors;
        limit        = 20 * fetches + 100;
        cycles       = 0;
        rst_ni       = 1'b0;
        boot_addr    = boot;
        fetch_rsp    = '0;
        trap         = '0;
        resolve      = '0;
        q_addr.delete();
        q_delay.delete();
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni      = 1'b1;
        m_pc        = '0;
        m_base      = '0;
        m_req       = 1'b0;
        m_pend      = 1'b0;
        m_boot      = 1'b1;
        m_sv        = 2'b00;
        fetch_count = 0;
        while (fetch_count < fetches) begin
            drive_inputs(rate);
            #1;
            step_model();
            capture_request();
            cycles++;
            if (cycles > limit) begin
                $display("test %s stopped: only %0d of %0d fetches after %0d cycles",
                         name, fetch_count, fetches, cycles);
                timed_out = 1'b1;
                errors++;
                break;
            end
            @(negedge clk_i);
        end
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("test %-10s %s errors=%0d fetches=%0d cycles=%0d", name,
                 (errors == start_errors) ? "ok" : "FAILED", errors - start_errors,
                 fetch_count, cycles);
    endtask

    initial begin
        rst_ni       = 1'b0;
        boot_addr    = '0;
        fetch_rsp    = '0;
        trap         = '0;
        resolve      = '0;
        lfsr_q       = 16'd64659;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        fill_random();
        run_test("boot", 32'h0000_0100, 6, 0);

        foreach (mem[i]) begin
            mem[i] = NOP;
        end
        run_test("sequential", 32'h0000_0200, 20, 0);

        // jal into an odd slot and then a forward branch that falls through
        // followed by a backward branch that loops
        mem[16] = enc_jal(32'h24);
        mem[25] = enc_branch(32'd8);
        mem[26] = enc_branch(-32'h28);
        run_test("prediction", 32'h0000_0040, 12, 0);

        fill_random();
        run_test("redirect", 32'h0000_0000, 60, 6);
        run_test("random", 32'h0000_0080, 300, 1);

        $display("tests=%0d failed=%0d errors=%0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_align.sv
design/cf_scan.sv
design/fetch_steer.sv
design/fetch_frontend.sv
verif/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch frontend testbench with Verilator and runs it
# exits nonzero when the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_fetch_frontend \
    -Mdir "$OBJ" -o tb_fetch_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_fetch_frontend" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
